// ==== logic/bp_pkg.sv ====
package bp_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Predictor geometry
    ////////////////////////////////////////////////////////////////////////////

    // Width of a fetch address and a branch target
    localparam int unsigned PC_BITS = 32;

    // Global history length
    localparam int unsigned GHR_BITS = 8;

    // Counter table index, 1K entries
    localparam int unsigned PHT_BITS = 10;
    localparam int unsigned PHT_ENTRIES = 1 << PHT_BITS;

    // BTB index and tag, 64 entries
    localparam int unsigned BTB_BITS = 6;
    localparam int unsigned BTB_ENTRIES = 1 << BTB_BITS;
    localparam int unsigned BTB_TAG_BITS = 8;

    // Byte offset within a 32-bit word
    localparam int unsigned PC_ALIGN_BITS = 2;

    // Two-bit saturating counter, upper bit means taken
    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'd0,
        WEAK_NOT_TAKEN   = 2'd1,
        WEAK_TAKEN       = 2'd2,
        STRONG_TAKEN     = 2'd3
    } counter_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Internal structs
    ////////////////////////////////////////////////////////////////////////////

    // Table indices derived from one pc and one history value
    typedef struct packed {
        logic [PHT_BITS-1:0]     pht_idx;
        logic [BTB_BITS-1:0]     btb_idx;
        logic [BTB_TAG_BITS-1:0] btb_tag;
    } bp_indices_t;

    // One BTB slot
    typedef struct packed {
        logic                    valid;
        logic [BTB_TAG_BITS-1:0] tag;
        logic [PC_BITS-1:0]      target;
    } btb_entry_t;

    // Fetch asks the predictor about pc
    typedef struct packed {
        logic               valid;
        logic [PC_BITS-1:0] pc;
    } predict_req_t;

    // Combined answer, same cycle
    typedef struct packed {
        logic                taken;
        logic [PC_BITS-1:0]  target;
        logic [GHR_BITS-1:0] ghr_snapshot;
    } predict_resp_t;

endpackage

// ==== logic/core_pkg.sv ====
package core_pkg;

    // Address and data width of the core
    localparam int unsigned XLEN = bp_pkg::PC_BITS;

    // First fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch packet, one per fetch cycle
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                          valid;
        logic [XLEN-1:0]               pc;
        logic                          pred_taken;
        logic [XLEN-1:0]               pred_target;
        // History seen by this fetch, carried down the pipe
        logic [bp_pkg::GHR_BITS-1:0]   ghr_snapshot;
    } fetch_packet_t;

    ////////////////////////////////////////////////////////////////////////////
    // Retire-side branch resolution
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                          valid;
        logic [XLEN-1:0]               pc;
        logic                          actual_taken;
        logic [XLEN-1:0]               actual_target;
        logic                          mispredict;
        logic [XLEN-1:0]               redirect_pc;
        logic [bp_pkg::GHR_BITS-1:0]   ghr_snapshot;
    } retire_update_t;

endpackage

// ==== logic/gshare_pht.sv ====
`timescale 1ns/1ps

module gshare_pht (
    input  logic                        clock,
    input  logic                        reset,
    // Prediction port
    input  logic [bp_pkg::PHT_BITS-1:0] read_index_i,
    output logic                        taken_o,
    // Training port
    input  logic [bp_pkg::PHT_BITS-1:0] write_index_i,
    input  logic                        write_en_i,
    input  logic                        write_taken_i
);

    import bp_pkg::*;

    // One step toward the resolved direction, clamped at both ends
    function automatic counter_state_e saturate(input counter_state_e state,
                                                input logic taken);
        counter_state_e next_state;
        next_state = state;
        unique case (state)
            STRONG_NOT_TAKEN: next_state = taken ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
            WEAK_NOT_TAKEN:   next_state = taken ? WEAK_TAKEN : STRONG_NOT_TAKEN;
            WEAK_TAKEN:       next_state = taken ? STRONG_TAKEN : WEAK_NOT_TAKEN;
            STRONG_TAKEN:     next_state = taken ? STRONG_TAKEN : WEAK_TAKEN;
        endcase
        return next_state;
    endfunction

    counter_state_e counters_q [PHT_ENTRIES];
    counter_state_e read_state;
    counter_state_e train_state;

    // Combinational read for the fetch cycle
    assign read_state = counters_q[read_index_i];
    assign taken_o    = read_state[1];

    // Old value of the trained slot
    assign train_state = counters_q[write_index_i];

    // Read-modify-write, new value seen next cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                counters_q[i] <= STRONG_NOT_TAKEN;
            end
        end else if (write_en_i) begin
            counters_q[write_index_i] <= saturate(train_state, write_taken_i);
        end
    end

endmodule

// ==== logic/branch_target_buffer.sv ====
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic                      clock,
    input  logic                      reset,
    // Lookup for the fetch pc
    input  bp_pkg::bp_indices_t       lookup_i,
    output logic                      hit_o,
    output logic [core_pkg::XLEN-1:0] target_o,
    // Allocation from retire on taken branches
    input  logic                      alloc_en_i,
    input  bp_pkg::bp_indices_t       alloc_i,
    input  logic [core_pkg::XLEN-1:0] alloc_target_i
);

    import bp_pkg::*;

    btb_entry_t entries_q [BTB_ENTRIES];
    btb_entry_t lookup_entry;
    btb_entry_t alloc_entry;

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////

    // Direct mapped, one slot per index
    assign lookup_entry = entries_q[lookup_i.btb_idx];

    // Hit needs a live entry and the same upper pc bits
    assign hit_o    = lookup_entry.valid && (lookup_entry.tag == lookup_i.btb_tag);
    assign target_o = lookup_entry.target;

    ////////////////////////////////////////////////////////////////////////////
    // Allocate
    ////////////////////////////////////////////////////////////////////////////

    // New entry replaces whatever sat in the slot
    always_comb begin
        alloc_entry.valid  = 1'b1;
        alloc_entry.tag    = alloc_i.btb_tag;
        alloc_entry.target = alloc_target_i;
    end

    // Only the valid bits are cleared at reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                entries_q[i].valid <= 1'b0;
            end
        end else if (alloc_en_i) begin
            entries_q[alloc_i.btb_idx] <= alloc_entry;
        end
    end

endmodule

// ==== logic/global_history.sv ====
`timescale 1ns/1ps

module global_history (
    input  logic                        clock,
    input  logic                        reset,
    // Speculative shift from fetch
    input  logic                        shift_en_i,
    input  logic                        shift_taken_i,
    // Recovery from retire
    input  logic                        restore_en_i,
    input  logic [bp_pkg::GHR_BITS-1:0] restore_snapshot_i,
    input  logic                        restore_taken_i,
    output logic [bp_pkg::GHR_BITS-1:0] history_o
);

    import bp_pkg::*;

    logic [GHR_BITS-1:0] history_q;
    logic [GHR_BITS-1:0] history_d;

    // Recovery wins over the speculative shift
    always_comb begin
        history_d = history_q;
        if (restore_en_i) begin
            // Snapshot as the branch saw it, plus its real outcome
            history_d = {restore_snapshot_i[GHR_BITS-2:0], restore_taken_i};
        end else if (shift_en_i) begin
            history_d = {history_q[GHR_BITS-2:0], shift_taken_i};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            history_q <= '0;
        end else begin
            history_q <= history_d;
        end
    end

    // Current history, newest outcome in bit 0
    assign history_o = history_q;

endmodule

// ==== logic/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor (
    input  logic                     clock,
    input  logic                     reset,
    input  bp_pkg::predict_req_t     predict_req_i,
    input  core_pkg::retire_update_t retire_i,
    output bp_pkg::predict_resp_t    predict_resp_o
);

    import core_pkg::*;
    import bp_pkg::*;

    // Table indices for one pc under one history value
    function automatic bp_indices_t compute_indices(input logic [XLEN-1:0] pc,
                                                    input logic [GHR_BITS-1:0] ghr);
        bp_indices_t idx;
        // gshare hash, history zero extended to the index width
        idx.pht_idx = pc[PC_ALIGN_BITS +: PHT_BITS]
                    ^ {{(PHT_BITS - GHR_BITS){1'b0}}, ghr};
        idx.btb_idx = pc[PC_ALIGN_BITS +: BTB_BITS];
        idx.btb_tag = pc[PC_ALIGN_BITS + BTB_BITS +: BTB_TAG_BITS];
        return idx;
    endfunction

    logic [GHR_BITS-1:0] history;
    bp_indices_t         predict_idx;
    bp_indices_t         train_idx;
    logic                pht_taken;
    logic                btb_hit;
    logic [XLEN-1:0]     btb_target;
    logic                final_taken;
    logic                train_en;
    logic                alloc_en;
    logic                recover_en;

    ////////////////////////////////////////////////////////////////////////////
    // Index and enable decode
    ////////////////////////////////////////////////////////////////////////////

    assign predict_idx = compute_indices(predict_req_i.pc, history);
    // Training uses the history the branch was fetched under
    assign train_idx   = compute_indices(retire_i.pc, retire_i.ghr_snapshot);

    assign train_en   = retire_i.valid;
    assign alloc_en   = retire_i.valid && retire_i.actual_taken;
    assign recover_en = retire_i.valid && retire_i.mispredict;

    // Direction
    gshare_pht u_pht (
        .clock         (clock),
        .reset         (reset),
        .read_index_i  (predict_idx.pht_idx),
        .taken_o       (pht_taken),
        .write_index_i (train_idx.pht_idx),
        .write_en_i    (train_en),
        .write_taken_i (retire_i.actual_taken)
    );

    // Target
    branch_target_buffer u_btb (
        .clock          (clock),
        .reset          (reset),
        .lookup_i       (predict_idx),
        .hit_o          (btb_hit),
        .target_o       (btb_target),
        .alloc_en_i     (alloc_en),
        .alloc_i        (train_idx),
        .alloc_target_i (retire_i.actual_target)
    );

    // Taken without a known target falls through to pc+4
    assign final_taken = pht_taken && btb_hit;

    // History
    global_history u_ghr (
        .clock              (clock),
        .reset              (reset),
        .shift_en_i         (predict_req_i.valid),
        .shift_taken_i      (final_taken),
        .restore_en_i       (recover_en),
        .restore_snapshot_i (retire_i.ghr_snapshot),
        .restore_taken_i    (retire_i.actual_taken),
        .history_o          (history)
    );

    always_comb begin
        predict_resp_o.taken        = final_taken;
        predict_resp_o.target       = final_taken ? btb_target : (predict_req_i.pc + XLEN'(4));
        predict_resp_o.ghr_snapshot = history;
    end

endmodule

// ==== logic/fetch_pc_unit.sv ====
`timescale 1ns/1ps

module fetch_pc_unit (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     stall_i,
    input  core_pkg::retire_update_t retire_i,
    // Same-cycle exchange with the predictor
    input  bp_pkg::predict_resp_t    predict_resp_i,
    output bp_pkg::predict_req_t     predict_req_o,
    output core_pkg::fetch_packet_t  fetch_o
);

    import core_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;
    logic            bubble_q;
    logic            redirect;
    logic            fetch_valid;

    assign redirect = retire_i.valid && retire_i.mispredict;

    // No fetch while stalled or in the dead cycle after a redirect
    assign fetch_valid = !stall_i && !bubble_q;

    ////////////////////////////////////////////////////////////////////////////
    // Next pc
    ////////////////////////////////////////////////////////////////////////////

    // Redirect ignores stall
    always_comb begin
        if (redirect) begin
            pc_d = retire_i.redirect_pc;
        end else if (!fetch_valid) begin
            pc_d = pc_q;
        end else begin
            pc_d = predict_resp_i.target;
        end
    end

    // Bubble comes up out of reset too, so valid stays low there
    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q     <= RESET_PC;
            bubble_q <= 1'b1;
        end else begin
            pc_q     <= pc_d;
            bubble_q <= redirect;
        end
    end

    assign predict_req_o.valid = fetch_valid;
    assign predict_req_o.pc    = pc_q;

    // Packet out
    always_comb begin
        fetch_o.valid        = fetch_valid;
        fetch_o.pc           = pc_q;
        fetch_o.pred_taken   = predict_resp_i.taken;
        fetch_o.pred_target  = predict_resp_i.target;
        fetch_o.ghr_snapshot = predict_resp_i.ghr_snapshot;
    end

endmodule

// ==== logic/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top (
    input  logic                     clock,
    input  logic                     reset,
    // Consumer back-pressure
    input  logic                     stall_i,
    // Branch resolution from retire
    input  core_pkg::retire_update_t retire_i,
    output core_pkg::fetch_packet_t  fetch_o
);

    import bp_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // PC unit to predictor, combinational both ways
    ////////////////////////////////////////////////////////////////////////////

    predict_req_t  predict_req;
    predict_resp_t predict_resp;

    // Owns the pc and the fetch packet
    fetch_pc_unit u_pc_unit (
        .clock          (clock),
        .reset          (reset),
        .stall_i        (stall_i),
        .retire_i       (retire_i),
        .predict_resp_i (predict_resp),
        .predict_req_o  (predict_req),
        .fetch_o        (fetch_o)
    );

    // Direction, target and history
    branch_predictor u_predictor (
        .clock          (clock),
        .reset          (reset),
        .predict_req_i  (predict_req),
        .retire_i       (retire_i),
        .predict_resp_o (predict_resp)
    );

endmodule

// ==== tb/frontend_sva.sv ====
`timescale 1ns/1ps

module frontend_sva (
    input logic                     clock,
    input logic                     reset,
    input core_pkg::retire_update_t retire_i,
    input core_pkg::fetch_packet_t  fetch_o
);

    logic redirect;

    // Retire asks for a new fetch path
    assign redirect = retire_i.valid && retire_i.mispredict;

    // Fetch addresses are whole words
    pc_word_aligned: assert property (@(posedge clock) disable iff (reset)
        fetch_o.pc[1:0] == 2'b00)
        else $error("fetch pc is not word aligned");

    // Dead cycle right after a redirect
    bubble_after_redirect: assert property (@(posedge clock) disable iff (reset)
        redirect |=> !fetch_o.valid)
        else $error("fetch valid high in the cycle after a mispredict");

    // New path starts at the corrected pc
    pc_follows_redirect: assert property (@(posedge clock) disable iff (reset)
        redirect |=> (fetch_o.pc == $past(retire_i.redirect_pc)))
        else $error("fetch pc differs from the previous redirect pc");

endmodule

bind fetch_pc_unit frontend_sva u_sva (
    .clock    (clock),
    .reset    (reset),
    .retire_i (retire_i),
    .fetch_o  (fetch_o)
);

// ==== tb/frontend_tb.sv ====
`timescale 1ns/1ps

module frontend_tb;

    import core_pkg::*;
    import bp_pkg::*;

    // Run length, used for the timeout
    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_CYCLES = 50;
    localparam int RANDOM_CYCLES   = 200;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;

    // Branches used by the directed tests
    localparam logic [XLEN-1:0]     BR_PC     = 32'h0000_2040;
    localparam logic [XLEN-1:0]     BR_TARGET = 32'h0000_3000;
    localparam logic [XLEN-1:0]     ALIAS_PC  = 32'h0000_4040;
    localparam logic [XLEN-1:0]     OTHER_PC  = 32'h0000_0500;
    localparam logic [GHR_BITS-1:0] HIST      = 8'hB5;
    localparam retire_update_t      NO_RETIRE = '0;

    logic           clock;
    logic           reset;
    logic           stall_i;
    retire_update_t retire_i;
    fetch_packet_t  fetch_o;

    // Reference model state
    logic [XLEN-1:0]         m_pc;
    logic                    m_bubble;
    logic [GHR_BITS-1:0]     m_ghr;
    counter_state_e          m_pht [PHT_ENTRIES];
    logic                    m_btb_valid [BTB_ENTRIES];
    logic [BTB_TAG_BITS-1:0] m_btb_tag [BTB_ENTRIES];
    logic [XLEN-1:0]         m_btb_target [BTB_ENTRIES];

    fetch_packet_t  exp_pkt;
    retire_update_t cur_retire;
    logic [31:0]    lcg_state;
    int             cycle_count;

    frontend_top UUT (
        .clock    (clock),
        .reset    (reset),
        .stall_i  (stall_i),
        .retire_i (retire_i),
        .fetch_o  (fetch_o)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
        abort_run();
    endtask

    task automatic check_fetch(input fetch_packet_t exp, input fetch_packet_t act);
        if (act.valid !== exp.valid)
            report_mismatch("fetch_o.valid", exp.valid, act.valid);
        if (act.pc !== exp.pc)
            report_mismatch("fetch_o.pc", exp.pc, act.pc);
        if (act.pred_taken !== exp.pred_taken)
            report_mismatch("fetch_o.pred_taken", exp.pred_taken, act.pred_taken);
        if (act.pred_target !== exp.pred_target)
            report_mismatch("fetch_o.pred_target", exp.pred_target, act.pred_target);
        if (act.ghr_snapshot !== exp.ghr_snapshot)
            report_mismatch("fetch_o.ghr_snapshot", exp.ghr_snapshot, act.ghr_snapshot);
    endtask

    task automatic check_counter(input counter_state_e exp, input counter_state_e act);
        if (act !== exp)
            report_mismatch("pht counter", exp, act);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // gshare hash, pc word index xor history
    function automatic logic [PHT_BITS-1:0] pht_index(input logic [XLEN-1:0] pc,
                                                      input logic [GHR_BITS-1:0] ghr);
        return pc[PC_ALIGN_BITS +: PHT_BITS] ^ PHT_BITS'(ghr);
    endfunction

    // Counter moves one step, stops at both ends
    function automatic counter_state_e trained(input counter_state_e c, input logic taken);
        if (taken && c != STRONG_TAKEN)
            return counter_state_e'(c + 2'd1);
        if (!taken && c != STRONG_NOT_TAKEN)
            return counter_state_e'(c - 2'd1);
        return c;
    endfunction

    function automatic retire_update_t make_retire(input logic [XLEN-1:0] pc,
            input logic taken, input logic [XLEN-1:0] target, input logic mispredict,
            input logic [XLEN-1:0] redirect_pc, input logic [GHR_BITS-1:0] snap);
        retire_update_t rt;
        rt.valid         = 1'b1;
        rt.pc            = pc;
        rt.actual_taken  = taken;
        rt.actual_target = target;
        rt.mispredict    = mispredict;
        rt.redirect_pc   = redirect_pc;
        rt.ghr_snapshot  = snap;
        return rt;
    endfunction

    function automatic fetch_packet_t make_packet(input logic valid,
            input logic [XLEN-1:0] pc, input logic taken, input logic [XLEN-1:0] target,
            input logic [GHR_BITS-1:0] snap);
        fetch_packet_t p;
        p.valid        = valid;
        p.pc           = pc;
        p.pred_taken   = taken;
        p.pred_target  = target;
        p.ghr_snapshot = snap;
        return p;
    endfunction

    // Drive on the falling edge, then compare with the model
    task automatic apply(input logic stall, input retire_update_t rt);
        logic [BTB_BITS-1:0]     bi;
        logic [BTB_TAG_BITS-1:0] tag;
        counter_state_e          ctr;
        logic                    hit;
        stall_i    = stall;
        retire_i   = rt;
        cur_retire = rt;
        #1;
        bi  = m_pc[PC_ALIGN_BITS +: BTB_BITS];
        tag = m_pc[PC_ALIGN_BITS + BTB_BITS +: BTB_TAG_BITS];
        ctr = m_pht[pht_index(m_pc, m_ghr)];
        hit = m_btb_valid[bi] && (m_btb_tag[bi] == tag);
        exp_pkt.valid        = !stall && !m_bubble;
        exp_pkt.pc           = m_pc;
        exp_pkt.pred_taken   = ctr[1] && hit;
        exp_pkt.pred_target  = exp_pkt.pred_taken ? m_btb_target[bi] : m_pc + 32'd4;
        exp_pkt.ghr_snapshot = m_ghr;
        check_fetch(exp_pkt, fetch_o);
    endtask

    // Clock edge in the model, then wait for the next falling edge
    task automatic advance();
        logic                redirect;
        logic [PHT_BITS-1:0] ti;
        logic [BTB_BITS-1:0] bi;
        redirect = cur_retire.valid && cur_retire.mispredict;
        if (cur_retire.valid) begin
            ti = pht_index(cur_retire.pc, cur_retire.ghr_snapshot);
            m_pht[ti] = trained(m_pht[ti], cur_retire.actual_taken);
            if (cur_retire.actual_taken) begin
                bi = cur_retire.pc[PC_ALIGN_BITS +: BTB_BITS];
                m_btb_valid[bi]  = 1'b1;
                m_btb_tag[bi]    = cur_retire.pc[PC_ALIGN_BITS + BTB_BITS +: BTB_TAG_BITS];
                m_btb_target[bi] = cur_retire.actual_target;
            end
        end
        if (redirect) begin
            m_ghr = {cur_retire.ghr_snapshot[GHR_BITS-2:0], cur_retire.actual_taken};
            m_pc  = cur_retire.redirect_pc;
        end else if (exp_pkt.valid) begin
            m_ghr = {m_ghr[GHR_BITS-2:0], exp_pkt.pred_taken};
            m_pc  = exp_pkt.pred_target;
        end
        m_bubble = redirect;
        @(negedge clock);
    endtask

    task automatic run_cycle(input logic stall, input retire_update_t rt);
        apply(stall, rt);
        advance();
    endtask

    // Mispredict whose recovery leaves exactly hist in the history
    task automatic redirect_to(input logic [XLEN-1:0] pc, input logic [GHR_BITS-1:0] hist);
        run_cycle(1'b0, make_retire(OTHER_PC, hist[0], pc, 1'b1, pc, {1'b0, hist[7:1]}));
        run_cycle(1'b0, NO_RETIRE);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_stream();
        for (int i = 0; i < 10; i++) begin
            apply(1'b0, NO_RETIRE);
            if (i == 0)
                check_fetch(make_packet(1'b0, RESET_PC, 1'b0, RESET_PC + 4, 8'h00), fetch_o);
            else
                check_fetch(make_packet(1'b1, RESET_PC + 4 * (i - 1), 1'b0,
                                        RESET_PC + 4 * i, 8'h00), fetch_o);
            advance();
        end
    endtask

    task automatic test_stall_hold();
        logic [XLEN-1:0]     held_pc;
        logic [GHR_BITS-1:0] held_ghr;
        // Non-zero history, so a shift under stall would change it
        redirect_to(m_pc, HIST);
        repeat (3) run_cycle(1'b0, NO_RETIRE);
        held_pc  = m_pc;
        // Three not-taken fetches since the redirect
        held_ghr = HIST << 3;
        for (int i = 0; i < 4; i++) begin
            apply(1'b1, NO_RETIRE);
            check_fetch(make_packet(1'b0, held_pc, 1'b0, held_pc + 4, held_ghr), fetch_o);
            advance();
        end
        apply(1'b0, NO_RETIRE);
        check_fetch(make_packet(1'b1, held_pc, 1'b0, held_pc + 4, held_ghr), fetch_o);
        advance();
        repeat (2) run_cycle(1'b0, NO_RETIRE);
    endtask

    task automatic test_trained_taken();
        fetch_packet_t exp;
        repeat (2) run_cycle(1'b0, make_retire(BR_PC, 1'b1, BR_TARGET, 1'b0, '0, HIST));
        check_counter(WEAK_TAKEN, UUT.u_predictor.u_pht.counters_q[pht_index(BR_PC, HIST)]);
        redirect_to(BR_PC, HIST);
        apply(1'b0, NO_RETIRE);
        check_fetch(make_packet(1'b1, BR_PC, 1'b1, BR_TARGET, HIST), fetch_o);
        advance();
        // Taken target becomes the next fetch pc
        apply(1'b0, NO_RETIRE);
        exp    = exp_pkt;
        exp.pc = BR_TARGET;
        check_fetch(exp, fetch_o);
        advance();
    endtask

    task automatic test_btb_alias();
        // Same BTB slot as BR_PC, different tag
        repeat (2) run_cycle(1'b0, make_retire(ALIAS_PC, 1'b1, 32'h5000, 1'b0, '0, HIST));
        run_cycle(1'b0, make_retire(BR_PC, 1'b1, BR_TARGET, 1'b0, '0, HIST));
        check_counter(STRONG_TAKEN, UUT.u_predictor.u_pht.counters_q[pht_index(ALIAS_PC, HIST)]);
        redirect_to(ALIAS_PC, HIST);
        apply(1'b0, NO_RETIRE);
        check_fetch(make_packet(1'b1, ALIAS_PC, 1'b0, ALIAS_PC + 4, HIST), fetch_o);
        advance();
    endtask

    task automatic test_stall_mispredict();
        fetch_packet_t exp;
        repeat (2) run_cycle(1'b0, NO_RETIRE);
        run_cycle(1'b1, make_retire(OTHER_PC, 1'b0, '0, 1'b1, 32'h6000, 8'h3C));
        apply(1'b0, NO_RETIRE);
        exp       = exp_pkt;
        exp.valid = 1'b0;
        exp.pc    = 32'h6000;
        check_fetch(exp, fetch_o);
        advance();
        // Recovered history is 3C shifted with a not-taken outcome
        apply(1'b0, NO_RETIRE);
        check_fetch(make_packet(1'b1, 32'h6000, 1'b0, 32'h6004, 8'h78), fetch_o);
        advance();
    endtask

    task automatic test_random_mix();
        logic [31:0]    r;
        logic           stall;
        retire_update_t rt;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r     = next_random();
            stall = (r[2:0] == 3'd0);
            rt    = NO_RETIRE;
            if (r[5:4] == 2'd0) begin
                // Mostly current pc and history, so trained entries get hit
                rt = make_retire(r[8] ? m_pc : (next_random() & 32'h0000_3FFC), r[9],
                                 next_random() & 32'h0000_7FFC, r[12:10] == 3'd0,
                                 next_random() & 32'h0000_7FFC, r[13] ? m_ghr : r[23:16]);
            end
            run_cycle(stall, rt);
        end
    endtask

    // Hang guard
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    initial begin
        reset       = 1'b1;
        stall_i     = 1'b0;
        retire_i    = '0;
        cur_retire  = '0;
        exp_pkt     = '0;
        cycle_count = 0;
        lcg_state   = 32'd70;
        m_pc        = RESET_PC;
        m_bubble    = 1'b1;
        m_ghr       = '0;
        for (int i = 0; i < PHT_ENTRIES; i++) m_pht[i] = STRONG_NOT_TAKEN;
        for (int i = 0; i < BTB_ENTRIES; i++) m_btb_valid[i] = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        test_reset_stream();
        test_stall_hold();
        test_trained_taken();
        test_btb_alias();
        test_stall_mispredict();
        test_random_mix();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== frontend_top.f ====
logic/bp_pkg.sv
logic/core_pkg.sv
logic/gshare_pht.sv
logic/branch_target_buffer.sv
logic/global_history.sv
logic/branch_predictor.sv
logic/fetch_pc_unit.sv
logic/frontend_top.sv
tb/frontend_sva.sv
tb/frontend_tb.sv
